//--- src/rf_cfg_pkg.sv
// Register file sizing for the small 32-bit core: register count and word widths
`default_nettype none

package rf_cfg_pkg;

  // Thirty-two architectural registers, x0 included
  localparam int rf_num_regs = 32;

  // Address width needed to select one of the registers
  localparam int rf_addr_w = $clog2(rf_num_regs);

  // Width of the data part of every register
  localparam int rf_data_w = 32;

endpackage

`default_nettype wire

//--- src/rf_ecc_pkg.sv
// Error-detecting code for the register file: check bits, masks and stored-word layout
`default_nettype none

package rf_ecc_pkg;
  import rf_cfg_pkg::*;

  // Six check bits guard every 32-bit data word
  localparam int ecc_check_w = 6;

  // The stored word keeps check bits on top of the data
  localparam int ecc_word_w = ecc_check_w + rf_data_w;

  // Check bit i is the parity of the data bits selected by mask i.
  // Read column-wise, each data bit has its own set of masks; every set is
  // distinct and holds at least two masks, so one or two flipped bits in
  // data or check bits always leave a nonzero syndrome
  localparam logic [ecc_check_w-1:0][rf_data_w-1:0] ecc_masks = {
    32'h93EF_FC00,
    32'h13DF_03F0,
    32'hCBB8_E38E,
    32'h2B74_9A6D,
    32'h46F2_555B,
    32'h25F1_2CB7
  };

  // XORed into the check bits so that a zero data word does not store as zeros
  localparam logic [ecc_check_w-1:0] ecc_invert = 6'h2a;

  // Content of every register after reset: zero data with its check bits
  localparam logic [ecc_word_w-1:0] ecc_zero_word = {ecc_invert, {rf_data_w{1'b0}}};

  // One stored word seen two ways.
  // The field view splits check bits from data to rebuild the syndrome,
  // the raw view compares the whole word against all zeros or all ones
  typedef union packed {
    struct packed {
      logic [ecc_check_w-1:0] check;
      logic [rf_data_w-1:0]   data;
    } f;
    logic [ecc_word_w-1:0] raw;
  } rf_word_u;

endpackage

`default_nettype wire

//--- src/rf_write_if.sv
// Write-back port bundle from the ECC encoder into the register file
`default_nettype none

interface rf_write_if
  import rf_cfg_pkg::*;
  import rf_ecc_pkg::*;
();

  // Write strobe, target register and the plain data being written
  logic                  we;
  logic [rf_addr_w-1:0]  waddr;
  logic [rf_data_w-1:0]  wdata;

  // Same data with its check bits, as it goes into the array
  logic [ecc_word_w-1:0] wword;

  // Encoder side drives everything
  modport source (output we, output waddr, output wdata, output wword);

  // Register file side only listens
  modport sink (input we, input waddr, input wdata, input wword);

endinterface

`default_nettype wire

//--- src/rf_read_if.sv
// Read port bundle carrying both source addresses and both registered stored words
`default_nettype none

interface rf_read_if
  import rf_cfg_pkg::*;
  import rf_ecc_pkg::*;
();

  // Source operand addresses, driven from the top level
  logic [rf_addr_w-1:0]  rs1_addr;
  logic [rf_addr_w-1:0]  rs2_addr;

  // Stored words after the read register, check bits still attached
  logic [ecc_word_w-1:0] rs1_word;
  logic [ecc_word_w-1:0] rs2_word;

  // Register file looks up the addresses and returns the words
  modport source (
    input  rs1_addr, input  rs2_addr,
    output rs1_word, output rs2_word
  );

  // The integrity checker needs the addresses as well, to leave x0 alone
  modport chk (
    input rs1_addr, input rs2_addr,
    input rs1_word, input rs2_word
  );

endinterface

`default_nettype wire

//--- src/rf_ecc_encoder.sv
// ECC encoder that adds six check bits to write-back data and forms the stored word
`default_nettype none

module rf_ecc_encoder
  import rf_cfg_pkg::*;
  import rf_ecc_pkg::*;
(
  input  logic                 we,
  input  logic [rf_addr_w-1:0] waddr,
  input  logic [rf_data_w-1:0] wdata,
  rf_write_if.source           wr
);

  // Raw mask parities before the inversion constant
  logic [ecc_check_w-1:0] parity;
  rf_word_u               enc_word;

  // One parity tree per check bit
  always_comb begin
    for (int i = 0; i < ecc_check_w; i++) begin
      parity[i] = ^(wdata & ecc_masks[i]);
    end
  end

  // Inverting a fixed pattern of check bits keeps zero data away from an
  // all-zeros stored word, and keeps all-ones data away from all ones
  always_comb begin
    enc_word.f.check = parity ^ ecc_invert;
    enc_word.f.data  = wdata;
  end

  // Strobe and address pass on untouched, alongside the encoded word
  assign wr.we    = we;
  assign wr.waddr = waddr;
  assign wr.wdata = wdata;
  assign wr.wword = enc_word.raw;

endmodule

`default_nettype wire

//--- src/rf_ecc_regfile.sv
// 32-entry ECC-protected register file with fault injection and registered dual read
`default_nettype none

module rf_ecc_regfile
  import rf_cfg_pkg::*;
  import rf_ecc_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  rf_write_if.sink              wr,
  rf_read_if.source             rd,
  input  logic                  rd_en,
  input  logic                  fi_en,
  input  logic [rf_addr_w-1:0]  fi_addr,
  input  logic [ecc_word_w-1:0] fi_mask
);

  // Only x1 to x31 have storage because x0 is a constant
  logic [ecc_word_w-1:0] mem [1:rf_num_regs-1];

  // Words picked by the read addresses before the read register
  logic [ecc_word_w-1:0] rs1_word_d;
  logic [ecc_word_w-1:0] rs2_word_d;

  // Read register that feeds the integrity checker
  logic [ecc_word_w-1:0] rs1_word_q;
  logic [ecc_word_w-1:0] rs2_word_q;

  // One update process per register.
  // Reset loads the encoded zero, so no register ever starts as all zeros.
  // A write in the same cycle as an injection overrides the bit flips
  for (genvar r = 1; r < rf_num_regs; r++) begin : g_reg
    always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
        mem[r] <= ecc_zero_word;
      end else if (wr.we && (wr.waddr == r)) begin
        mem[r] <= wr.wword;
      end else if (fi_en && (fi_addr == r)) begin
        // The glitch model flips the chosen data and check bits in place
        mem[r] <= mem[r] ^ fi_mask;
      end
    end
  end

  // Address zero returns the encoded zero word, which passes every check
  always_comb begin
    if (rd.rs1_addr == '0) begin
      rs1_word_d = ecc_zero_word;
    end else begin
      rs1_word_d = mem[rd.rs1_addr];
    end
    if (rd.rs2_addr == '0) begin
      rs2_word_d = ecc_zero_word;
    end else begin
      rs2_word_d = mem[rd.rs2_addr];
    end
  end

  // Both ports are captured by the one read strobe.
  // The words are held between reads; rd_en marks when they are fresh
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rs1_word_q <= rs1_word_d;
      rs2_word_q <= rs2_word_d;
    end
  end

  // Words leave raw and the checker decodes them
  assign rd.rs1_word = rs1_word_q;
  assign rd.rs2_word = rs2_word_q;

endmodule

`default_nettype wire

//--- src/rf_integrity_checker.sv
// Integrity checker that decodes both read words and raises a one-cycle major alert
`default_nettype none

module rf_integrity_checker
  import rf_cfg_pkg::*;
  import rf_ecc_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  rf_read_if.chk               rd,
  input  logic                 rd_en,
  output logic [rf_data_w-1:0] rs1_rdata,
  output logic [rf_data_w-1:0] rs2_rdata,
  output logic                 rd_valid,
  output logic                 alert_major
);

  // Read strobe and addresses, one stage late to line up with the read register
  logic                 rd_pend;
  logic [rf_addr_w-1:0] rs1_addr_q;
  logic [rf_addr_w-1:0] rs2_addr_q;

  // Registered words in their decoded form
  rf_word_u rs1_w;
  rf_word_u rs2_w;
  logic     rs1_err;
  logic     rs2_err;

  // A word is bad if its syndrome is nonzero, or if it is stuck at all zeros
  // or all ones, which a whole-word glitch tends to produce
  function automatic logic word_error(input rf_word_u w);
    logic [ecc_check_w-1:0] syndrome;
    for (int i = 0; i < ecc_check_w; i++) begin
      syndrome[i] = ^(w.f.data & ecc_masks[i]);
    end
    syndrome = syndrome ^ ecc_invert ^ w.f.check;
    return (syndrome != '0) || (w.raw == '0) || (w.raw == '1);
  endfunction

  assign rs1_w = rd.rs1_word;
  assign rs2_w = rd.rs2_word;

  // x0 is never checked
  assign rs1_err = (rs1_addr_q != '0) && word_error(rs1_w);
  assign rs2_err = (rs2_addr_q != '0) && word_error(rs2_w);

  // Same edge as the register file read register
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rs1_addr_q <= rd.rs1_addr;
      rs2_addr_q <= rd.rs2_addr;
    end
  end

  // Valid and alert are pulses, one cycle per read
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rd_pend     <= 1'b0;
      rd_valid    <= 1'b0;
      alert_major <= 1'b0;
    end else begin
      rd_pend     <= rd_en;
      rd_valid    <= rd_pend;
      alert_major <= rd_pend && (rs1_err || rs2_err);
    end
  end

  // Data is returned raw, with no correction; x0 is forced to zero
  always_ff @(posedge clk_i) begin
    if (rd_pend) begin
      rs1_rdata <= (rs1_addr_q == '0) ? '0 : rs1_w.f.data;
      rs2_rdata <= (rs2_addr_q == '0) ? '0 : rs2_w.f.data;
    end
  end

endmodule

`default_nettype wire

//--- src/gpr_ecc_top.sv
// Top level of the ECC-guarded general purpose register file with its integrity checker
`default_nettype none

module gpr_ecc_top
  import rf_cfg_pkg::*;
  import rf_ecc_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Write-back port
  input  logic                  we,
  input  logic [rf_addr_w-1:0]  waddr,
  input  logic [rf_data_w-1:0]  wdata,
  // Operand read port
  input  logic                  rd_en,
  input  logic [rf_addr_w-1:0]  rs1_addr,
  input  logic [rf_addr_w-1:0]  rs2_addr,
  // Fault injection port
  input  logic                  fi_en,
  input  logic [rf_addr_w-1:0]  fi_addr,
  input  logic [ecc_word_w-1:0] fi_mask,
  // Read results and alert
  output logic [rf_data_w-1:0]  rs1_rdata,
  output logic [rf_data_w-1:0]  rs2_rdata,
  output logic                  rd_valid,
  output logic                  alert_major
);

  rf_write_if wr_if ();
  rf_read_if  rd_if ();

  // Read addresses enter the read bundle here
  assign rd_if.rs1_addr = rs1_addr;
  assign rd_if.rs2_addr = rs2_addr;

  rf_ecc_encoder i_rf_ecc_encoder (
    .we    (we),
    .waddr (waddr),
    .wdata (wdata),
    .wr    (wr_if.source)
  );

  rf_ecc_regfile i_rf_ecc_regfile (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wr      (wr_if.sink),
    .rd      (rd_if.source),
    .rd_en   (rd_en),
    .fi_en   (fi_en),
    .fi_addr (fi_addr),
    .fi_mask (fi_mask)
  );

  // Checker sees the same strobe so it can line up with the read register
  rf_integrity_checker i_rf_integrity_checker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd          (rd_if.chk),
    .rd_en       (rd_en),
    .rs1_rdata   (rs1_rdata),
    .rs2_rdata   (rs2_rdata),
    .rd_valid    (rd_valid),
    .alert_major (alert_major)
  );

endmodule

`default_nettype wire

//--- verification/tb_gpr_ecc_vectors.svh
// Operation table for the register file testbench, with the row layout and row count
`ifndef TB_GPR_ECC_VECTORS_SVH
`define TB_GPR_ECC_VECTORS_SVH

// What a row does in its cycle
// A combined write and inject row hits one register with both strobes
typedef enum logic [2:0] {op_idle, op_write, op_read, op_inject, op_wrinj} vec_op_e;

// For writes and injections addr1 is the target register
// For reads addr1 goes to rs1 and addr2 to rs2
// With rnd set, a write gets random data at the start of the run and a read
// takes its expected values from the reference model
typedef struct {
  string                 name;
  vec_op_e               op;
  bit                    rnd;
  logic [rf_addr_w-1:0]  addr1;
  logic [rf_addr_w-1:0]  addr2;
  logic [rf_data_w-1:0]  data;
  logic [ecc_word_w-1:0] mask;
  logic [rf_data_w-1:0]  exp1;
  logic [rf_data_w-1:0]  exp2;
  logic                  exp_alert;
} vec_row_t;

localparam int vec_rows = 53;

vec_row_t vecs [vec_rows] = '{
  // Every register straight after reset, two per read
  '{"rst_p00", op_read, 1'b0, 5'd0, 5'd1, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rst_p01", op_read, 1'b0, 5'd2, 5'd3, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rst_p02", op_read, 1'b0, 5'd4, 5'd5, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rst_p03", op_read, 1'b0, 5'd6, 5'd7, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rst_p04", op_read, 1'b0, 5'd8, 5'd9, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rst_p05", op_read, 1'b0, 5'd10, 5'd11, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rst_p06", op_read, 1'b0, 5'd12, 5'd13, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rst_p07", op_read, 1'b0, 5'd14, 5'd15, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rst_p08", op_read, 1'b0, 5'd16, 5'd17, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rst_p09", op_read, 1'b0, 5'd18, 5'd19, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rst_p10", op_read, 1'b0, 5'd20, 5'd21, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rst_p11", op_read, 1'b0, 5'd22, 5'd23, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rst_p12", op_read, 1'b0, 5'd24, 5'd25, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rst_p13", op_read, 1'b0, 5'd26, 5'd27, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rst_p14", op_read, 1'b0, 5'd28, 5'd29, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rst_p15", op_read, 1'b0, 5'd30, 5'd31, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  // Random writes, a dropped write to x0, then three reads back to back
  '{"wr_x1", op_write, 1'b1, 5'd1, 5'd0, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"wr_x2", op_write, 1'b1, 5'd2, 5'd0, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"wr_x3", op_write, 1'b1, 5'd3, 5'd0, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"wr_x31", op_write, 1'b1, 5'd31, 5'd0, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"wr_x0", op_write, 1'b0, 5'd0, 5'd0, 32'hdead_beef, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rd_1_2", op_read, 1'b1, 5'd1, 5'd2, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rd_3_31", op_read, 1'b1, 5'd3, 5'd31, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rd_0_1", op_read, 1'b1, 5'd0, 5'd1, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  // Single flips in a data bit and in a check bit, seen on either port
  '{"wr_x5", op_write, 1'b0, 5'd5, 5'd0, 32'h1234_5678, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"wr_x6", op_write, 1'b0, 5'd6, 5'd0, 32'h0f0f_0f0f, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rd_5_6", op_read, 1'b0, 5'd5, 5'd6, 32'h0, 38'h0, 32'h1234_5678, 32'h0f0f_0f0f, 1'b0},
  '{"fi_x5_d3", op_inject, 1'b0, 5'd5, 5'd0, 32'h0, 38'h8, 32'h0, 32'h0, 1'b0},
  '{"rd_5_6f", op_read, 1'b0, 5'd5, 5'd6, 32'h0, 38'h0, 32'h1234_5670, 32'h0f0f_0f0f, 1'b1},
  '{"rd_6_5f", op_read, 1'b0, 5'd6, 5'd5, 32'h0, 38'h0, 32'h0f0f_0f0f, 32'h1234_5670, 1'b1},
  '{"fi_x6_c0", op_inject, 1'b0, 5'd6, 5'd0, 32'h0, 38'h01_0000_0000, 32'h0, 32'h0, 1'b0},
  '{"rd_6_0f", op_read, 1'b0, 5'd6, 5'd0, 32'h0, 38'h0, 32'h0f0f_0f0f, 32'h0, 1'b1},
  '{"fi_x3_d31", op_inject, 1'b0, 5'd3, 5'd0, 32'h0, 38'h00_8000_0000, 32'h0, 32'h0, 1'b0},
  '{"rd_1_3f", op_read, 1'b1, 5'd1, 5'd3, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  // Double flips, two data bits on x7 and a check bit plus a data bit on x2
  '{"wr_x7", op_write, 1'b0, 5'd7, 5'd0, 32'haaaa_5555, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"fi_x7_dd", op_inject, 1'b0, 5'd7, 5'd0, 32'h0, 38'h11, 32'h0, 32'h0, 1'b0},
  '{"rd_7_0dd", op_read, 1'b0, 5'd7, 5'd0, 32'h0, 38'h0, 32'haaaa_5544, 32'h0, 1'b1},
  '{"fi_x2_cd", op_inject, 1'b0, 5'd2, 5'd0, 32'h0, 38'h02_0000_0001, 32'h0, 32'h0, 1'b0},
  '{"rd_31_2", op_read, 1'b1, 5'd31, 5'd2, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  // Reset words on x20 and x21 pushed to all zeros and all ones
  '{"fi_x20_z", op_inject, 1'b0, 5'd20, 5'd0, 32'h0, 38'h2a_0000_0000, 32'h0, 32'h0, 1'b0},
  '{"rd_20_0z", op_read, 1'b0, 5'd20, 5'd0, 32'h0, 38'h0, 32'h0, 32'h0, 1'b1},
  '{"fi_x21_o", op_inject, 1'b0, 5'd21, 5'd0, 32'h0, 38'h15_ffff_ffff, 32'h0, 32'h0, 1'b0},
  '{"rd_0_21o", op_read, 1'b0, 5'd0, 5'd21, 32'h0, 38'h0, 32'h0, 32'hffff_ffff, 1'b1},
  '{"fi_x0", op_inject, 1'b0, 5'd0, 5'd0, 32'h0, 38'h3f_ffff_ffff, 32'h0, 32'h0, 1'b0},
  '{"rd_0_0", op_read, 1'b0, 5'd0, 5'd0, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  // Fresh writes repair corrupted words, and a write beats a same-cycle injection
  '{"wr_x5c", op_write, 1'b0, 5'd5, 5'd0, 32'hcafe_f00d, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"wr_x6c", op_write, 1'b0, 5'd6, 5'd0, 32'h0000_0001, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rd_5_6c", op_read, 1'b0, 5'd5, 5'd6, 32'h0, 38'h0, 32'hcafe_f00d, 32'h0000_0001, 1'b0},
  '{"wi_x7", op_wrinj, 1'b0, 5'd7, 5'd0, 32'h7777_0000, 38'h3f_ffff_ffff, 32'h0, 32'h0, 1'b0},
  '{"rd_7_0c", op_read, 1'b0, 5'd7, 5'd0, 32'h0, 38'h0, 32'h7777_0000, 32'h0, 1'b0},
  '{"wr_x3c", op_write, 1'b1, 5'd3, 5'd0, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rd_3_1c", op_read, 1'b1, 5'd3, 5'd1, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0},
  '{"rd_2_31", op_read, 1'b1, 5'd2, 5'd31, 32'h0, 38'h0, 32'h0, 32'h0, 1'b0}
};

`endif

//--- verification/tb_gpr_ecc_top.sv
// Testbench for the ECC-guarded register file, run from a table with a reference model
`default_nettype none

module tb_gpr_ecc_top
  import rf_cfg_pkg::*;
  import rf_ecc_pkg::*;
();

  `include "tb_gpr_ecc_vectors.svh"

  // Run limit in clock cycles, reset included
  localparam int max_cycles = 4 * vec_rows + 40;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  we;
  logic [rf_addr_w-1:0]  waddr;
  logic [rf_data_w-1:0]  wdata;
  logic                  rd_en;
  logic [rf_addr_w-1:0]  rs1_addr;
  logic [rf_addr_w-1:0]  rs2_addr;
  logic                  fi_en;
  logic [rf_addr_w-1:0]  fi_addr;
  logic [ecc_word_w-1:0] fi_mask;
  logic [rf_data_w-1:0]  rs1_rdata;
  logic [rf_data_w-1:0]  rs2_rdata;
  logic                  rd_valid;
  logic                  alert_major;

  // Reference copy of every stored word in which the x0 slot stays at the reset word
  logic [ecc_word_w-1:0] model_mem [rf_num_regs];
  // Rows whose read results are still in the pipeline, oldest first
  int                    pend [$];
  int                    cycles = 0;
  integer                seed;

  gpr_ecc_top i_gpr_ecc_top (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .we          (we),
    .waddr       (waddr),
    .wdata       (wdata),
    .rd_en       (rd_en),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .fi_en       (fi_en),
    .fi_addr     (fi_addr),
    .fi_mask     (fi_mask),
    .rs1_rdata   (rs1_rdata),
    .rs2_rdata   (rs2_rdata),
    .rd_valid    (rd_valid),
    .alert_major (alert_major)
  );

  always #4 clk_i = ~clk_i;

  // Check bits are the mask parities of the data with the inversion constant on top
  function automatic logic [ecc_word_w-1:0] encode_word(input logic [rf_data_w-1:0] d);
    logic [ecc_check_w-1:0] chk;
    for (int i = 0; i < ecc_check_w; i++) begin
      chk[i] = ^(d & ecc_masks[i]);
    end
    return {chk ^ ecc_invert, d};
  endfunction

  // A word is bad when its check bits no longer match its data, or when it is
  // all zeros or all ones
  function automatic logic word_is_bad(input logic [rf_addr_w-1:0] a,
                                       input logic [ecc_word_w-1:0] w);
    logic bad;
    bad = (encode_word(w[rf_data_w-1:0]) != w) || (w == '0) || (&w);
    return (a != '0) && bad;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic compare_value(input string test, input string what,
                               input logic [rf_data_w-1:0] exp,
                               input logic [rf_data_w-1:0] act);
    assert (act === exp) else begin
      stop_on_error($sformatf("MISMATCH %s %s expected %h actual %h", test, what, exp, act));
    end
  endtask

  // All inputs idle, strobes low
  task automatic clear_inputs();
    we       = 1'b0;
    waddr    = '0;
    wdata    = '0;
    rd_en    = 1'b0;
    rs1_addr = '0;
    rs2_addr = '0;
    fi_en    = 1'b0;
    fi_addr  = '0;
    fi_mask  = '0;
  endtask

  // Expected data and alert of a random read, from the model as it stands now
  task automatic predict_read(input int i);
    logic [ecc_word_w-1:0] w1;
    logic [ecc_word_w-1:0] w2;
    w1 = model_mem[vecs[i].addr1];
    w2 = model_mem[vecs[i].addr2];
    vecs[i].exp1      = (vecs[i].addr1 == '0) ? '0 : w1[rf_data_w-1:0];
    vecs[i].exp2      = (vecs[i].addr2 == '0) ? '0 : w2[rf_data_w-1:0];
    vecs[i].exp_alert = word_is_bad(vecs[i].addr1, w1) || word_is_bad(vecs[i].addr2, w2);
  endtask

  // Drives one row and moves the model along with it
  task automatic apply_row(input int i);
    clear_inputs();
    waddr    = vecs[i].addr1;
    wdata    = vecs[i].data;
    fi_addr  = vecs[i].addr1;
    fi_mask  = vecs[i].mask;
    rs1_addr = vecs[i].addr1;
    rs2_addr = vecs[i].addr2;
    case (vecs[i].op)
      op_write, op_wrinj: begin
        // The write lands even when an injection hits the same register
        we    = 1'b1;
        fi_en = (vecs[i].op == op_wrinj);
        if (vecs[i].addr1 != '0) begin
          model_mem[vecs[i].addr1] = encode_word(vecs[i].data);
        end
      end
      op_inject: begin
        fi_en = 1'b1;
        if (vecs[i].addr1 != '0) begin
          model_mem[vecs[i].addr1] = model_mem[vecs[i].addr1] ^ vecs[i].mask;
        end
      end
      op_read: begin
        rd_en = 1'b1;
        if (vecs[i].rnd) begin
          predict_read(i);
        end
        pend.push_back(i);
      end
      default: begin
      end
    endcase
  endtask

  // A read driven in cycle c shows its results two falling edges later
  task automatic check_cycle(input int c);
    int r;
    if ((pend.size() > 0) && (pend[0] == c - 2)) begin
      r = pend.pop_front();
      compare_value(vecs[r].name, "rd_valid", 32'd1, rf_data_w'(rd_valid));
      compare_value(vecs[r].name, "rs1_rdata", vecs[r].exp1, rs1_rdata);
      compare_value(vecs[r].name, "rs2_rdata", vecs[r].exp2, rs2_rdata);
      compare_value(vecs[r].name, "alert_major", rf_data_w'(vecs[r].exp_alert),
                    rf_data_w'(alert_major));
    end else begin
      compare_value($sformatf("cycle_%0d", c), "rd_valid", 32'd0, rf_data_w'(rd_valid));
      compare_value($sformatf("cycle_%0d", c), "alert_major", 32'd0, rf_data_w'(alert_major));
    end
  endtask

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      stop_on_error($sformatf("The run timed out after %0d clock cycles", max_cycles));
    end
  end

  initial begin
    seed   = 32'h2d8e8e29;
    rst_ni = 1'b0;
    clear_inputs();
    for (int r = 0; r < rf_num_regs; r++) begin
      model_mem[r] = ecc_zero_word;
    end
    // Random data for the marked write rows is drawn once, up front
    for (int i = 0; i < vec_rows; i++) begin
      if (vecs[i].rnd && (vecs[i].op == op_write)) begin
        vecs[i].data = $random(seed);
      end
    end
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    // Two extra cycles let the last reads come out
    for (int c = 0; c < vec_rows + 2; c++) begin
      check_cycle(c);
      if (c < vec_rows) begin
        apply_row(c);
      end else begin
        clear_inputs();
      end
      @(negedge clk_i);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verification
src/rf_cfg_pkg.sv
src/rf_ecc_pkg.sv
src/rf_write_if.sv
src/rf_read_if.sv
src/rf_ecc_encoder.sv
src/rf_ecc_regfile.sv
src/rf_integrity_checker.sv
src/gpr_ecc_top.sv
verification/tb_gpr_ecc_top.sv
